//--- Bender.yml
package:
  name: cpu_system

sources:
  - cpu_pkg.sv
  - cpu_datapath.sv
  - cpu_control.sv
  - cpu.sv
  - instr_mem.sv
  - data_mem.sv
  - cpu_system.sv
  - target: simulation
    files:
      - tb_cpu_system.sv

//--- cpu.sv
`timescale 1ns/1ps

module cpu #(
   parameter int  NB_BITS       = 16,
   parameter int  INS_MEM_DEPTH = 2048,
   parameter int  DTA_MEM_DEPTH = 1024,
   localparam int NB_OPERAND    = NB_BITS - cpu_pkg::NB_OPCODE,
   localparam int NB_ADDR_INS   = cpu_pkg::clogb2(INS_MEM_DEPTH),
   localparam int NB_ADDR_DATA  = cpu_pkg::clogb2(DTA_MEM_DEPTH)
) (
   input  logic                    i_clk,
   input  logic                    i_rst,
   input  logic                    i_run,
   input  logic [NB_BITS-1:0]      i_instruction,
   input  logic [NB_BITS-1:0]      i_data_mem,
   output logic [NB_ADDR_INS-1:0]  o_addr_ins,
   output logic [NB_ADDR_DATA-1:0] o_addr_data,
   output logic [NB_BITS-1:0]      o_data,
   output logic [NB_BITS-1:0]      o_acc,
   output logic                    o_wr,
   output logic                    o_rd,
   output logic                    o_halted
);

   logic [NB_OPERAND-1:0] data_ins;
   cpu_pkg::acc_src_e     sel_a;
   logic                  sel_b;
   logic                  wr_acc;
   logic                  op_code;

   // data address is the low part of the operand.
   assign o_addr_data = data_ins[NB_ADDR_DATA-1:0];

   cpu_control #(
      .NB_BITS       (NB_BITS),
      .INS_MEM_DEPTH (INS_MEM_DEPTH),
      .DTA_MEM_DEPTH (DTA_MEM_DEPTH)
   ) u_control (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_run         (i_run),
      .i_instruction (i_instruction),
      .o_addr_ins    (o_addr_ins),
      .o_data_ins    (data_ins),
      .o_sel_a       (sel_a),
      .o_sel_b       (sel_b),
      .o_wr_acc      (wr_acc),
      .o_op_code     (op_code),
      .o_wr          (o_wr),
      .o_rd          (o_rd),
      .o_halted      (o_halted)
   );

   cpu_datapath #(
      .NB_BITS       (NB_BITS),
      .DTA_MEM_DEPTH (DTA_MEM_DEPTH)
   ) u_datapath (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_data_mem    (i_data_mem),
      .i_data_ins    (data_ins),
      .i_sel_a       (sel_a),
      .i_sel_b       (sel_b),
      .i_wr_acc      (wr_acc),
      .i_op_code     (op_code),
      .o_acc         (o_acc),
      .o_data        (o_data)
   );

endmodule

//--- cpu_control.sv
`timescale 1ns/1ps

module cpu_control #(
   parameter int  NB_BITS       = 16,
   parameter int  INS_MEM_DEPTH = 2048,
   parameter int  DTA_MEM_DEPTH = 1024,
   localparam int NB_OPERAND    = NB_BITS - cpu_pkg::NB_OPCODE,
   localparam int NB_ADDR_INS   = cpu_pkg::clogb2(INS_MEM_DEPTH),
   localparam int NB_ADDR_DATA  = cpu_pkg::clogb2(DTA_MEM_DEPTH)
) (
   input  logic                    i_clk,
   input  logic                    i_rst,
   input  logic                    i_run,
   input  logic [NB_BITS-1:0]      i_instruction,
   output logic [NB_ADDR_INS-1:0]  o_addr_ins,
   output logic [NB_OPERAND-1:0]   o_data_ins,
   output cpu_pkg::acc_src_e       o_sel_a,
   output logic                    o_sel_b,
   output logic                    o_wr_acc,
   output logic                    o_op_code,
   output logic                    o_wr,
   output logic                    o_rd,
   output logic                    o_halted
);

   typedef enum logic {
      ST_RUN  = 1'b0,
      ST_HALT = 1'b1
   } state_e;

   state_e                 state_q;
   state_e                 state_d;
   logic [NB_ADDR_INS-1:0] pc_q;
   cpu_pkg::opcode_e       opcode;
   logic                   active;

   assign opcode     = cpu_pkg::opcode_e'(i_instruction[NB_BITS-1 -: cpu_pkg::NB_OPCODE]);
   assign o_data_ins = i_instruction[NB_OPERAND-1:0];

   assign active = i_run && (state_q == ST_RUN);

   always_comb begin
      o_sel_a   = cpu_pkg::ACC_ALU;
      o_sel_b   = 1'b0;
      o_op_code = 1'b0;
      o_wr_acc  = 1'b0;
      o_wr      = 1'b0;
      o_rd      = 1'b0;
      state_d   = state_q;
      if (active) begin
         case (opcode)
            cpu_pkg::HLT: begin
               state_d = ST_HALT;
            end
            cpu_pkg::STO: begin
               o_wr = 1'b1;
            end
            cpu_pkg::LD: begin
               o_sel_a  = cpu_pkg::ACC_MEM;
               o_rd     = 1'b1;
               o_wr_acc = 1'b1;
            end
            cpu_pkg::LDI: begin
               o_sel_a  = cpu_pkg::ACC_IMM;
               o_wr_acc = 1'b1;
            end
            cpu_pkg::ADD, cpu_pkg::SUB: begin
               o_rd      = 1'b1;
               o_op_code = (opcode == cpu_pkg::SUB);
               o_wr_acc  = 1'b1;
            end
            cpu_pkg::ADDI, cpu_pkg::SUBI: begin
               o_sel_b   = 1'b1;
               o_op_code = (opcode == cpu_pkg::SUBI);
               o_wr_acc  = 1'b1;
            end
            default: begin
               // unused codes only advance the pc.
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q <= ST_RUN;
         pc_q    <= '0;
      end else begin
         state_q <= state_d;
         // pc parks on the halt address.
         if (active && (opcode != cpu_pkg::HLT)) begin
            pc_q <= pc_q + 1'b1;
         end
      end
   end

   assign o_addr_ins = pc_q;
   assign o_halted   = (state_q == ST_HALT);

endmodule

//--- cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath #(
   parameter int  NB_BITS       = 16,
   parameter int  DTA_MEM_DEPTH = 1024,
   localparam int NB_OPERAND    = NB_BITS - cpu_pkg::NB_OPCODE
) (
   input  logic                    i_clk,
   input  logic                    i_rst,
   input  logic [NB_BITS-1:0]      i_data_mem,
   input  logic [NB_OPERAND-1:0]   i_data_ins,
   input  cpu_pkg::acc_src_e       i_sel_a,
   input  logic                    i_sel_b,
   input  logic                    i_wr_acc,
   input  logic                    i_op_code,
   output logic [NB_BITS-1:0]      o_acc,
   output logic [NB_BITS-1:0]      o_data
);

   logic [NB_BITS-1:0] acc_q;
   logic [NB_BITS-1:0] acc_d;
   logic [NB_BITS-1:0] imm_ext;
   logic [NB_BITS-1:0] operand_b;
   logic [NB_BITS-1:0] alu_out;

   // immediates are two's complement.
   assign imm_ext = {{(NB_BITS-NB_OPERAND){i_data_ins[NB_OPERAND-1]}}, i_data_ins};

   assign operand_b = i_sel_b ? imm_ext : i_data_mem;

   // wraps modulo 2^NB_BITS.
   assign alu_out = i_op_code ? (acc_q - operand_b) : (acc_q + operand_b);

   always_comb begin
      case (i_sel_a)
         cpu_pkg::ACC_MEM: acc_d = i_data_mem;
         cpu_pkg::ACC_IMM: acc_d = imm_ext;
         default:          acc_d = alu_out;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         acc_q <= '0;
      end else if (i_wr_acc) begin
         acc_q <= acc_d;
      end
   end

   assign o_acc  = acc_q;
   // store data is the accumulator itself.
   assign o_data = acc_q;

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

   // width of the opcode field at the top of every instruction.
   localparam int NB_OPCODE = 5;

   // codes outside this list decode as a no-operation.
   typedef enum logic [NB_OPCODE-1:0] {
      HLT  = 5'd0,
      STO  = 5'd1,
      LD   = 5'd2,
      LDI  = 5'd3,
      ADD  = 5'd4,
      ADDI = 5'd5,
      SUB  = 5'd6,
      SUBI = 5'd7
   } opcode_e;

   // next accumulator source.
   typedef enum logic [1:0] {
      ACC_MEM = 2'd0,
      ACC_IMM = 2'd1,
      ACC_ALU = 2'd2
   } acc_src_e;

   // address width needed to reach every word of a memory of the given depth.
   function automatic int clogb2(input int depth);
      int width;
      int value;
      width = 0;
      value = depth - 1;
      while (value > 0) begin
         width = width + 1;
         value = value >> 1;
      end
      if (width == 0) begin
         width = 1;
      end
      return width;
   endfunction

endpackage

//--- cpu_system.sv
`timescale 1ns/1ps

module cpu_system #(
   parameter int  NB_BITS       = 16,
   parameter int  INS_MEM_DEPTH = 2048,
   parameter int  DTA_MEM_DEPTH = 1024,
   localparam int NB_ADDR_INS   = cpu_pkg::clogb2(INS_MEM_DEPTH),
   localparam int NB_ADDR_DATA  = cpu_pkg::clogb2(DTA_MEM_DEPTH)
) (
   input  logic                    i_clk,
   input  logic                    i_rst,
   input  logic                    i_run,
   input  logic                    i_prog_we,
   input  logic [NB_ADDR_INS-1:0]  i_prog_addr,
   input  logic [NB_BITS-1:0]      i_prog_data,
   output logic [NB_BITS-1:0]      o_acc,
   output logic [NB_ADDR_INS-1:0]  o_pc,
   output logic                    o_halted,
   output logic                    o_mem_wr,
   output logic [NB_ADDR_DATA-1:0] o_mem_addr,
   output logic [NB_BITS-1:0]      o_mem_wdata
);

   logic [NB_BITS-1:0] instruction;
   logic [NB_BITS-1:0] mem_rdata;
   logic               mem_rd;

   cpu #(
      .NB_BITS       (NB_BITS),
      .INS_MEM_DEPTH (INS_MEM_DEPTH),
      .DTA_MEM_DEPTH (DTA_MEM_DEPTH)
   ) u_cpu (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_run         (i_run),
      .i_instruction (instruction),
      .i_data_mem    (mem_rdata),
      .o_addr_ins    (o_pc),
      .o_addr_data   (o_mem_addr),
      .o_data        (o_mem_wdata),
      .o_acc         (o_acc),
      .o_wr          (o_mem_wr),
      .o_rd          (mem_rd),
      .o_halted      (o_halted)
   );

   instr_mem #(
      .NB_BITS       (NB_BITS),
      .INS_MEM_DEPTH (INS_MEM_DEPTH)
   ) u_imem (
      .i_clk         (i_clk),
      .i_we          (i_prog_we),
      .i_waddr       (i_prog_addr),
      .i_wdata       (i_prog_data),
      .i_raddr       (o_pc),
      .o_rdata       (instruction)
   );

   data_mem #(
      .NB_BITS       (NB_BITS),
      .DTA_MEM_DEPTH (DTA_MEM_DEPTH)
   ) u_dmem (
      .i_clk         (i_clk),
      .i_wr          (o_mem_wr),
      .i_rd          (mem_rd),
      .i_addr        (o_mem_addr),
      .i_wdata       (o_mem_wdata),
      .o_rdata       (mem_rdata)
   );

endmodule

//--- data_mem.sv
`timescale 1ns/1ps

module data_mem #(
   parameter int  NB_BITS       = 16,
   parameter int  DTA_MEM_DEPTH = 1024,
   localparam int NB_ADDR       = cpu_pkg::clogb2(DTA_MEM_DEPTH)
) (
   input  logic               i_clk,
   input  logic               i_wr,
   input  logic               i_rd,
   input  logic [NB_ADDR-1:0] i_addr,
   input  logic [NB_BITS-1:0] i_wdata,
   output logic [NB_BITS-1:0] o_rdata
);

   logic [NB_BITS-1:0] mem [DTA_MEM_DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_wr) begin
         mem[i_addr] <= i_wdata;
      end
   end

   // idle read bus sits at zero.
   assign o_rdata = i_rd ? mem[i_addr] : '0;

endmodule

//--- instr_mem.sv
`timescale 1ns/1ps

module instr_mem #(
   parameter int  NB_BITS       = 16,
   parameter int  INS_MEM_DEPTH = 2048,
   localparam int NB_ADDR       = cpu_pkg::clogb2(INS_MEM_DEPTH)
) (
   input  logic               i_clk,
   input  logic               i_we,
   input  logic [NB_ADDR-1:0] i_waddr,
   input  logic [NB_BITS-1:0] i_wdata,
   input  logic [NB_ADDR-1:0] i_raddr,
   output logic [NB_BITS-1:0] o_rdata
);

   logic [NB_BITS-1:0] mem [INS_MEM_DEPTH];

   // program load port.
   always_ff @(posedge i_clk) begin
      if (i_we) begin
         mem[i_waddr] <= i_wdata;
      end
   end

   // fetch returns the word in the same cycle.
   assign o_rdata = mem[i_raddr];

endmodule

//--- src.f
cpu_pkg.sv
cpu_datapath.sv
cpu_control.sv
cpu.sv
instr_mem.sv
data_mem.sv
cpu_system.sv
tb_cpu_system.sv

//--- tb_cpu_system.sv
`timescale 1ns/1ps

module tb_cpu_system;

   localparam int NB_BITS       = 16;
   localparam int INS_MEM_DEPTH = 2048;
   localparam int DTA_MEM_DEPTH = 1024;
   localparam int NB_OPC        = cpu_pkg::NB_OPCODE;
   localparam int NB_OPERAND    = NB_BITS - NB_OPC;
   localparam int NB_ADDR_INS   = cpu_pkg::clogb2(INS_MEM_DEPTH);
   localparam int NB_ADDR_DATA  = cpu_pkg::clogb2(DTA_MEM_DEPTH);
   localparam int RESET_CYCLES  = 5;
   localparam int FREEZE_CYCLES = 10;

   logic                    i_clk;
   logic                    i_rst;
   logic                    i_run;
   logic                    i_prog_we;
   logic [NB_ADDR_INS-1:0]  i_prog_addr;
   logic [NB_BITS-1:0]      i_prog_data;
   logic [NB_BITS-1:0]      o_acc;
   logic [NB_ADDR_INS-1:0]  o_pc;
   logic                    o_halted;
   logic                    o_mem_wr;
   logic [NB_ADDR_DATA-1:0] o_mem_addr;
   logic [NB_BITS-1:0]      o_mem_wdata;

   // reference model state.
   logic [NB_BITS-1:0]      m_acc;
   logic [NB_ADDR_INS-1:0]  m_pc;
   logic                    m_halted;
   logic                    m_bad_load;
   logic [NB_BITS-1:0]      m_mem [DTA_MEM_DEPTH];
   bit                      m_written [DTA_MEM_DEPTH];

   logic [NB_BITS-1:0]      prog_words [INS_MEM_DEPTH];
   logic [NB_BITS-1:0]      program_q [$];
   logic [NB_BITS-1:0]      cur_instr;
   logic                    exp_wr;
   integer                  seed;
   int                      cycle_count;
   int                      cycle_limit;

   cpu_system #(
      .NB_BITS       (NB_BITS),
      .INS_MEM_DEPTH (INS_MEM_DEPTH),
      .DTA_MEM_DEPTH (DTA_MEM_DEPTH)
   ) u_dut (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_run       (i_run),
      .i_prog_we   (i_prog_we),
      .i_prog_addr (i_prog_addr),
      .i_prog_data (i_prog_data),
      .o_acc       (o_acc),
      .o_pc        (o_pc),
      .o_halted    (o_halted),
      .o_mem_wr    (o_mem_wr),
      .o_mem_addr  (o_mem_addr),
      .o_mem_wdata (o_mem_wdata)
   );

   initial begin
      i_clk = 1'b0;
      forever #20 i_clk = ~i_clk;
   end

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   always @(posedge i_clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         fail_run($sformatf("timeout: cycle limit of %0d reached at %0t", cycle_limit, $time));
      end
   end

   task automatic check_acc(input logic [NB_BITS-1:0] got, input logic [NB_BITS-1:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("mismatch at %0t: accumulator is %h, expected %h", $time, got, exp));
      end
   endtask

   task automatic check_pc(input logic [NB_ADDR_INS-1:0] got, input logic [NB_ADDR_INS-1:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("mismatch at %0t: pc is %0d, expected %0d", $time, got, exp));
      end
   endtask

   task automatic check_halted(input logic got, input logic exp);
      if (got !== exp) begin
         fail_run($sformatf("mismatch at %0t: halted is %b, expected %b", $time, got, exp));
      end
   endtask

   task automatic check_store(input logic got_wr, input logic [NB_ADDR_DATA-1:0] got_addr,
                              input logic [NB_BITS-1:0] got_data, input logic exp_wr_i,
                              input logic [NB_ADDR_DATA-1:0] exp_addr,
                              input logic [NB_BITS-1:0] exp_data);
      if (got_wr !== exp_wr_i) begin
         fail_run($sformatf("mismatch at %0t: store strobe is %b, expected %b",
                            $time, got_wr, exp_wr_i));
      end
      if (exp_wr_i && (got_addr !== exp_addr || got_data !== exp_data)) begin
         fail_run($sformatf("mismatch at %0t: store %h to %0d, expected %h to %0d",
                            $time, got_data, got_addr, exp_data, exp_addr));
      end
   endtask

   // next model state from one instruction, following the instruction set rules.
   function automatic void model_step(input logic [NB_BITS-1:0] instr);
      logic [NB_OPC-1:0]       op;
      logic [NB_OPERAND-1:0]   operand;
      logic [NB_BITS-1:0]      imm;
      logic [NB_ADDR_DATA-1:0] addr;
      op      = instr[NB_BITS-1 -: NB_OPC];
      operand = instr[NB_OPERAND-1:0];
      imm     = {{(NB_BITS - NB_OPERAND){operand[NB_OPERAND-1]}}, operand};
      addr    = operand[NB_ADDR_DATA-1:0];
      if ((op == cpu_pkg::LD || op == cpu_pkg::ADD || op == cpu_pkg::SUB) && !m_written[addr]) begin
         m_bad_load = 1'b1;
      end
      case (op)
         cpu_pkg::HLT:  m_halted = 1'b1;
         cpu_pkg::STO: begin
            m_mem[addr]     = m_acc;
            m_written[addr] = 1'b1;
         end
         cpu_pkg::LD:   m_acc = m_mem[addr];
         cpu_pkg::LDI:  m_acc = imm;
         cpu_pkg::ADD:  m_acc = m_acc + m_mem[addr];
         cpu_pkg::ADDI: m_acc = m_acc + imm;
         cpu_pkg::SUB:  m_acc = m_acc - m_mem[addr];
         cpu_pkg::SUBI: m_acc = m_acc - imm;
         default: ;
      endcase
      if (op != cpu_pkg::HLT) begin
         m_pc = m_pc + 1'b1;
      end
   endfunction

   // outputs are stable mid-cycle; the model then steps for the coming edge.
   always @(negedge i_clk) begin
      if (i_rst) begin
         m_acc    = '0;
         m_pc     = '0;
         m_halted = 1'b0;
      end else begin
         cur_instr = prog_words[m_pc];
         exp_wr    = i_run && !m_halted && (cur_instr[NB_BITS-1 -: NB_OPC] == cpu_pkg::STO);
         check_pc(o_pc, m_pc);
         check_acc(o_acc, m_acc);
         check_halted(o_halted, m_halted);
         check_store(o_mem_wr, o_mem_addr, o_mem_wdata, exp_wr,
                     cur_instr[NB_ADDR_DATA-1:0], m_acc);
         if (i_run && !m_halted) begin
            model_step(cur_instr);
            if (m_bad_load) begin
               fail_run("test program reads a data address it never wrote");
            end
         end
      end
   end

   function automatic logic [NB_BITS-1:0] encode(input logic [NB_OPC-1:0] op, input int operand);
      return {op, operand[NB_OPERAND-1:0]};
   endfunction

   task automatic apply_reset();
      @(posedge i_clk);
      #2 i_rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge i_clk);
      #2 i_rst = 1'b0;
   endtask

   task automatic load_program();
      for (int i = 0; i < program_q.size(); i++) begin
         @(posedge i_clk);
         #2;
         i_prog_we     = 1'b1;
         i_prog_addr   = i;
         i_prog_data   = program_q[i];
         prog_words[i] = program_q[i];
      end
      @(posedge i_clk);
      #2 i_prog_we = 1'b0;
   endtask

   task automatic run_program();
      cycle_limit = cycle_limit + 2 * program_q.size() + RESET_CYCLES + FREEZE_CYCLES + 20;
      apply_reset();
      load_program();
      @(posedge i_clk);
      #2 i_run = 1'b1;
      do @(negedge i_clk); while (!o_halted);
      // halted core must stay frozen.
      repeat (FREEZE_CYCLES) @(posedge i_clk);
      #2 i_run = 1'b0;
      @(posedge i_clk);
   endtask

   task automatic build_immediate();
      program_q.push_back(encode(cpu_pkg::LDI, 1023));
      program_q.push_back(encode(cpu_pkg::ADDI, -1024));
      program_q.push_back(encode(cpu_pkg::ADDI, 1));
      program_q.push_back(encode(cpu_pkg::SUBI, 1));
      program_q.push_back(encode(cpu_pkg::LDI, -1024));
      program_q.push_back(encode(cpu_pkg::SUBI, 1023));
      program_q.push_back(encode(cpu_pkg::SUBI, -1024));
      program_q.push_back(encode(cpu_pkg::LDI, 0));
      // long enough to wrap past 0xffff.
      for (int i = 0; i < 70; i++) begin
         program_q.push_back(encode(cpu_pkg::ADDI, 1023));
      end
      program_q.push_back(encode(cpu_pkg::LDI, -1));
      program_q.push_back(encode(cpu_pkg::SUBI, -1));
      program_q.push_back(encode(cpu_pkg::HLT, 0));
   endtask

   task automatic build_memory();
      program_q.push_back(encode(cpu_pkg::LDI, 100));
      program_q.push_back(encode(cpu_pkg::STO, 5));
      program_q.push_back(encode(cpu_pkg::LDI, -7));
      program_q.push_back(encode(cpu_pkg::STO, 1023));
      program_q.push_back(encode(cpu_pkg::LD, 5));
      program_q.push_back(encode(cpu_pkg::ADD, 1023));
      program_q.push_back(encode(cpu_pkg::SUB, 5));
      program_q.push_back(encode(cpu_pkg::STO, 1100));
      program_q.push_back(encode(cpu_pkg::LDI, 0));
      program_q.push_back(encode(cpu_pkg::LD, 76));
      program_q.push_back(encode(cpu_pkg::ADD, 5));
      program_q.push_back(encode(cpu_pkg::SUB, 1023));
      program_q.push_back(encode(5'd8, 33));
      program_q.push_back(encode(5'd31, -1));
      program_q.push_back(encode(cpu_pkg::LDI, 42));
      program_q.push_back(encode(5'd17, 5));
      program_q.push_back(encode(cpu_pkg::STO, 6));
      program_q.push_back(encode(cpu_pkg::LD, 6));
      program_q.push_back(encode(cpu_pkg::HLT, 0));
   endtask

   task automatic build_random(input int count);
      logic [NB_ADDR_DATA-1:0] written_q [$];
      logic [NB_OPC-1:0]       op;
      int                      kind;
      int                      operand;
      for (int i = 0; i < count - 1; i++) begin
         kind    = $unsigned($random(seed)) % 10;
         operand = $unsigned($random(seed)) % 2048;
         case (kind)
            0, 7:    op = cpu_pkg::STO;
            1:       op = cpu_pkg::LD;
            2, 8:    op = cpu_pkg::LDI;
            3:       op = cpu_pkg::ADD;
            4:       op = cpu_pkg::SUB;
            5:       op = cpu_pkg::ADDI;
            6:       op = cpu_pkg::SUBI;
            default: op = 8 + (operand % 24);
         endcase
         if (op == cpu_pkg::LD || op == cpu_pkg::ADD || op == cpu_pkg::SUB) begin
            if (written_q.size() == 0) begin
               op = cpu_pkg::STO;
            end else begin
               // bit 10 of the operand lies above the data address.
               operand = written_q[$unsigned($random(seed)) % written_q.size()]
                         + ($unsigned($random(seed)) % 2) * 1024;
            end
         end
         if (op == cpu_pkg::STO) begin
            written_q.push_back(operand[NB_ADDR_DATA-1:0]);
         end
         program_q.push_back(encode(op, operand));
      end
      program_q.push_back(encode(cpu_pkg::HLT, 0));
   endtask

   initial begin
      i_rst       = 1'b1;
      i_run       = 1'b0;
      i_prog_we   = 1'b0;
      i_prog_addr = '0;
      i_prog_data = '0;
      seed        = 32'h8ba56cdc;
      cycle_count = 0;
      cycle_limit = 0;
      m_bad_load  = 1'b0;

      program_q.delete();
      build_immediate();
      run_program();

      program_q.delete();
      build_memory();
      run_program();

      program_q.delete();
      build_random(200);
      run_program();

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule
